/* verilog/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Address and APB data width
`define ICACHE_XLEN 32

// Number of direct-mapped lines
`define ICACHE_NUMLINES 16

// Width of one cache line in bits
`define ICACHE_LINESIZE 256

// APB word reads needed to fill one line
`define ICACHE_WORDSPERLINE 8

`endif

/* verilog/icacheTypesPkg.sv */
`include "icache_cfg.svh"

package icacheTypesPkg;

    // Field widths of a cache address
    localparam int offsetBits = $clog2(`ICACHE_LINESIZE / 8);
    localparam int setBits    = $clog2(`ICACHE_NUMLINES);
    localparam int tagBits    = `ICACHE_XLEN - setBits - offsetBits;

    // Byte address split into tag, set and line offset
    typedef struct packed {
        logic [tagBits-1:0]    tag;
        logic [setBits-1:0]    set;
        logic [offsetBits-1:0] offset;
    } cacheAddr;

    // Fetch request from the core
    typedef struct packed {
        logic                    valid;
        logic [`ICACHE_XLEN-1:0] pc;
    } fetchReq;

    // Instruction window returned to the core
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } fetchResp;

    // Refill write into the line memory
    typedef struct packed {
        logic                        we;
        logic [`ICACHE_XLEN-1:0]     addr;
        logic [`ICACHE_LINESIZE-1:0] line;
    } lineWrite;

endpackage

/* verilog/busPkg.sv */
`include "icache_cfg.svh"

package busPkg;

    // APB master outputs
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`ICACHE_XLEN-1:0] paddr;
    } apbReq;

    // APB slave outputs
    typedef struct packed {
        logic                    pready;
        logic [`ICACHE_XLEN-1:0] prdata;
    } apbResp;

    // Cache controller sequencing
    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlLookup,
        ctrlRefill,
        ctrlReplay,
        ctrlFlushing
    } ctrlState;

    // APB transfer phases of the line fetcher
    typedef enum logic [1:0] {
        fetchIdle,
        fetchSetup,
        fetchAccess
    } fetchState;

endpackage

/* verilog/icacheMem.sv */
`include "icache_cfg.svh"

module icacheMem (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     readEnable,
    input  icacheTypesPkg::cacheAddr readAddr,
    input  logic                     flush,
    input  icacheTypesPkg::lineWrite lineIn,
    output logic [31:0]              dataWord,
    output logic                     dataValid
);

    localparam int numLines   = `ICACHE_NUMLINES;
    localparam int lineSize   = `ICACHE_LINESIZE;
    localparam int tagBits    = icacheTypesPkg::tagBits;
    localparam int offsetBits = icacheTypesPkg::offsetBits;
    localparam int halfBits   = 16;

    // Storage arrays
    logic [lineSize-1:0] lineMem [numLines];
    logic [tagBits-1:0]  tagMem  [numLines];
    logic [numLines-1:0] validBits;

    // Read side state
    icacheTypesPkg::cacheAddr addrReg;
    logic [lineSize-1:0]      readLine;
    logic [tagBits-1:0]       readTag;
    logic                     readValid;

    // Write side address fields
    icacheTypesPkg::cacheAddr writeAddr;

    // Window select
    logic [offsetBits-2:0]        halfSel;
    logic [lineSize+halfBits-1:0] paddedLine;

    assign writeAddr = icacheTypesPkg::cacheAddr'(lineIn.addr);

    // Refill writes line and tag in one cycle
    always_ff @(posedge clk) begin
        if (lineIn.we) begin
            lineMem[writeAddr.set] <= lineIn.line;
            tagMem[writeAddr.set]  <= writeAddr.tag;
        end
    end

    // Valid bits cleared all at once by flush
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            validBits <= '0;
        end else if (flush) begin
            validBits <= '0;
        end else if (lineIn.we) begin
            validBits[writeAddr.set] <= 1'b1;
        end
    end

    // Set index comes from the incoming address
    // Tag compare and halfword select use the registered copy
    always_ff @(posedge clk) begin
        if (readEnable) begin
            addrReg  <= readAddr;
            readLine <= lineMem[readAddr.set];
            readTag  <= tagMem[readAddr.set];
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
        end else if (readEnable) begin
            readValid <= validBits[readAddr.set];
        end
    end

    assign dataValid = readValid && (readTag == addrReg.tag);

    // Halfword index within the line
    assign halfSel = addrReg.offset[offsetBits-1:1];

    // Zero halfword above the line top for the last window
    assign paddedLine = {{halfBits{1'b0}}, readLine};

    // 32-bit window starting at the selected halfword
    assign dataWord = paddedLine[halfSel * halfBits +: 32];

endmodule

/* verilog/icacheLineFetch.sv */
`include "icache_cfg.svh"

module icacheLineFetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [`ICACHE_XLEN-1:0]  lineAddr,
    input  busPkg::apbResp           apbIn,
    output busPkg::apbReq            apbOut,
    output icacheTypesPkg::lineWrite lineOut,
    output logic                     done
);

    localparam int wordsPerLine = `ICACHE_WORDSPERLINE;
    localparam int wordBits     = `ICACHE_XLEN;
    localparam int idxBits      = $clog2(wordsPerLine);
    localparam int byteBits     = $clog2(wordBits / 8);

    busPkg::fetchState state;
    busPkg::fetchState nextState;

    // Burst progress
    logic [idxBits-1:0]     wordIdx;
    logic                   lastWord;
    logic                   beatDone;
    logic                   launch;
    logic                   doneReg;

    // Line being assembled
    logic [wordBits-1:0]                   baseAddr;
    logic [wordsPerLine-1:0][wordBits-1:0] lineBuf;

    assign launch   = start && (state == busPkg::fetchIdle);
    assign beatDone = (state == busPkg::fetchAccess) && apbIn.pready;
    assign lastWord = (wordIdx == idxBits'(wordsPerLine - 1));

    // Setup then access for every word of the burst
    always_comb begin
        nextState = state;
        case (state)
            busPkg::fetchIdle: begin
                if (start) begin
                    nextState = busPkg::fetchSetup;
                end
            end
            busPkg::fetchSetup: begin
                nextState = busPkg::fetchAccess;
            end
            busPkg::fetchAccess: begin
                if (apbIn.pready) begin
                    nextState = lastWord ? busPkg::fetchIdle : busPkg::fetchSetup;
                end
            end
            default: begin
                nextState = busPkg::fetchIdle;
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state   <= busPkg::fetchIdle;
            wordIdx <= '0;
            doneReg <= 1'b0;
        end else begin
            state   <= nextState;
            doneReg <= beatDone && lastWord;
            if (launch) begin
                wordIdx <= '0;
            end else if (beatDone) begin
                wordIdx <= wordIdx + 1'b1;
            end
        end
    end

    // Lowest address lands in the lowest bits of the line
    always_ff @(posedge clk) begin
        if (launch) begin
            baseAddr <= lineAddr;
        end
        if (beatDone) begin
            lineBuf[wordIdx] <= apbIn.prdata;
        end
    end

    // Address and select stay fixed until pready
    always_comb begin
        apbOut.psel    = (state != busPkg::fetchIdle);
        apbOut.penable = (state == busPkg::fetchAccess);
        apbOut.pwrite  = 1'b0;
        apbOut.paddr   = baseAddr + {wordIdx, {byteBits{1'b0}}};
    end

    // Write enable and done pulse together after the last word
    always_comb begin
        lineOut.we   = doneReg;
        lineOut.addr = baseAddr;
        lineOut.line = lineBuf;
    end

    assign done = doneReg;

endmodule

/* verilog/icacheController.sv */
`include "icache_cfg.svh"

module icacheController (
    input  logic                     clk,
    input  logic                     reset,
    input  icacheTypesPkg::fetchReq  req,
    input  logic                     flush,
    input  logic                     dataValid,
    input  logic [31:0]              dataWord,
    input  logic                     done,
    output logic                     ready,
    output logic                     readEnable,
    output icacheTypesPkg::cacheAddr readAddr,
    output icacheTypesPkg::fetchResp resp,
    output logic                     flushMem,
    output logic                     start,
    output logic [`ICACHE_XLEN-1:0]  lineAddr
);

    localparam int offsetBits = icacheTypesPkg::offsetBits;

    busPkg::ctrlState         state;
    busPkg::ctrlState         nextState;
    icacheTypesPkg::cacheAddr heldAddr;
    logic                     respValid;
    logic [31:0]              respInstr;
    logic                     hit;
    logic                     accept;
    logic                     replaying;

    assign hit       = (state == busPkg::ctrlLookup) && dataValid;
    assign replaying = (state == busPkg::ctrlReplay);

    // Ready drops in the same cycle a miss shows up
    assign ready  = (state == busPkg::ctrlIdle) || hit;
    assign accept = req.valid && ready;

    assign readEnable = accept || replaying;
    assign readAddr   = replaying ? heldAddr : icacheTypesPkg::cacheAddr'(req.pc);

    // Refill of the aligned line holding the missed pc
    assign start    = (state == busPkg::ctrlLookup) && !dataValid;
    assign lineAddr = {heldAddr.tag, heldAddr.set, {offsetBits{1'b0}}};
    assign flushMem = (state == busPkg::ctrlFlushing);

    always_comb begin
        nextState = state;
        case (state)
            busPkg::ctrlIdle: begin
                // A new request takes priority over flush
                if (accept) begin
                    nextState = busPkg::ctrlLookup;
                end else if (flush) begin
                    nextState = busPkg::ctrlFlushing;
                end
            end
            busPkg::ctrlLookup: begin
                if (!dataValid) begin
                    nextState = busPkg::ctrlRefill;
                end else if (!accept) begin
                    nextState = busPkg::ctrlIdle;
                end
            end
            busPkg::ctrlRefill: begin
                if (done) begin
                    nextState = busPkg::ctrlReplay;
                end
            end
            busPkg::ctrlReplay: begin
                nextState = busPkg::ctrlLookup;
            end
            default: begin
                nextState = busPkg::ctrlIdle;
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state     <= busPkg::ctrlIdle;
            respValid <= 1'b0;
        end else begin
            state     <= nextState;
            respValid <= hit;
        end
    end

    // Outstanding lookup address and response data
    always_ff @(posedge clk) begin
        if (accept) begin
            heldAddr <= icacheTypesPkg::cacheAddr'(req.pc);
        end
        if (hit) begin
            respInstr <= dataWord;
        end
    end

    assign resp = {respValid, respInstr};

endmodule

/* verilog/icacheTop.sv */
module icacheTop (
    input  logic                    clk,
    input  logic                    reset,
    input  icacheTypesPkg::fetchReq fetchReq,
    input  logic                    flush,
    input  busPkg::apbResp          apbIn,
    output logic                    fetchReady,
    output icacheTypesPkg::fetchResp fetchResp,
    output busPkg::apbReq           apbOut
);

    // Controller to memory
    logic                     readEnable;
    icacheTypesPkg::cacheAddr readAddr;
    logic                     flushMem;

    // Memory to controller
    logic [31:0]              dataWord;
    logic                     dataValid;

    // Controller and line fetcher handshake
    logic                     start;
    logic [31:0]              lineAddr;
    logic                     done;

    // Refill path into the memory
    icacheTypesPkg::lineWrite lineWrite;

    icacheController controllerInst (
        .clk        (clk),
        .reset      (reset),
        .req        (fetchReq),
        .flush      (flush),
        .dataValid  (dataValid),
        .dataWord   (dataWord),
        .done       (done),
        .ready      (fetchReady),
        .readEnable (readEnable),
        .readAddr   (readAddr),
        .resp       (fetchResp),
        .flushMem   (flushMem),
        .start      (start),
        .lineAddr   (lineAddr)
    );

    icacheLineFetch lineFetchInst (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .lineAddr (lineAddr),
        .apbIn    (apbIn),
        .apbOut   (apbOut),
        .lineOut  (lineWrite),
        .done     (done)
    );

    icacheMem memInst (
        .clk        (clk),
        .reset      (reset),
        .readEnable (readEnable),
        .readAddr   (readAddr),
        .flush      (flushMem),
        .lineIn     (lineWrite),
        .dataWord   (dataWord),
        .dataValid  (dataValid)
    );

endmodule

/* tests/clockGen.sv */
module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfPeriod  = 20;
    localparam int resetCycles = 16;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Release reset just after an edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

/* tests/icacheTop_assertions.sv */
module icacheTop_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     fetchReady,
    input icacheTypesPkg::fetchResp fetchResp,
    input busPkg::apbReq            apbOut,
    input busPkg::apbResp           apbIn
);
    timeunit 1ns;
    timeprecision 1ps;

    // One setup cycle then access with the same address
    setupToAccess: assert property (@(posedge clk) disable iff (reset)
        apbOut.psel && !apbOut.penable |=> apbOut.psel && apbOut.penable && $stable(apbOut.paddr))
        else $error("APB setup phase not followed by a matching access phase");

    enableAfterSetup: assert property (@(posedge clk) disable iff (reset)
        $rose(apbOut.penable) |-> $past(apbOut.psel && !apbOut.penable))
        else $error("APB penable rose without a setup phase");

    // Access holds until pready
    accessStable: assert property (@(posedge clk) disable iff (reset)
        apbOut.penable && !apbIn.pready |=> apbOut.psel && apbOut.penable && $stable(apbOut.paddr))
        else $error("APB access phase changed before pready");

    // Requester stalled and silent while the line is refilled
    quietRefill: assert property (@(posedge clk) disable iff (reset)
        apbOut.psel |-> !fetchReady && !fetchResp.valid)
        else $error("Fetch ready or response during a refill");

endmodule

/* tests/icacheTop_tb.sv */
`include "icache_cfg.svh"

module icacheTop_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          resetCycles  = 16;
    localparam int          driveDelay   = 2;
    localparam int          wordsPerLine = `ICACHE_WORDSPERLINE;
    localparam logic [31:0] memMask      = 32'h5A00_00C3;
    localparam string       testFile     = "tests/icacheTop_tests.txt";

    logic                     clk;
    logic                     reset;
    icacheTypesPkg::fetchReq  fetchReq;
    logic                     flush;
    busPkg::apbResp           apbIn;
    logic                     fetchReady;
    icacheTypesPkg::fetchResp fetchResp;
    busPkg::apbReq            apbOut;

    // Test table from the data file
    string       opList[$];
    string       nameList[$];
    logic [31:0] addrList[$];
    logic [31:0] windowList[$];
    int          readsList[$];

    // Accepted fetches awaiting a response, oldest first
    int pendingTest[$];
    int pendingCycle[$];

    int   cycleCount = 0;
    int   cycleLimit = 0;
    int   readCount;
    int   lastReadCount;
    int   issueIdx;
    int   flushPhase;
    int   seed;
    int   waitLeft;
    logic inAccess;

    clockGen clockGenInst (
        .clk   (clk),
        .reset (reset)
    );

    icacheTop icacheTop_inst (
        .clk        (clk),
        .reset      (reset),
        .fetchReq   (fetchReq),
        .flush      (flush),
        .apbIn      (apbIn),
        .fetchReady (fetchReady),
        .fetchResp  (fetchResp),
        .apbOut     (apbOut)
    );

    bind icacheTop icacheTop_assertions assertionsInst (
        .clk        (clk),
        .reset      (reset),
        .fetchReady (fetchReady),
        .fetchResp  (fetchResp),
        .apbOut     (apbOut),
        .apbIn      (apbIn)
    );

    task automatic abortRun();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", testName, expected, actual);
            abortRun();
        end
    endtask

    // Backing memory contents
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return addr ^ memMask;
    endfunction

    function automatic logic [31:0] lineBase(input logic [31:0] addr);
        return {addr[31:5], 5'b0};
    endfunction

    function automatic logic allDone();
        return (issueIdx >= opList.size()) && (pendingTest.size() == 0) && (flushPhase == 0);
    endfunction

    task automatic loadTests();
        int               fd;
        int               got;
        string            word;
        string            name;
        logic [31:0]      addr;
        logic [31:0]      window;
        int               reads;
        logic [8*200-1:0] skipLine;
        logic             atEnd;
        fd = $fopen(testFile, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", testFile);
            abortRun();
        end
        atEnd = 1'b0;
        while (!atEnd) begin
            got = $fscanf(fd, "%s", word);
            if (got != 1) begin
                atEnd = 1'b1;
            end else if (word == "#") begin
                got = $fgets(skipLine, fd);
            end else begin
                got = $fscanf(fd, "%s %h %h %d", name, addr, window, reads);
                if (got != 4 || (word != "fetch" && word != "flush")) begin
                    $display("Malformed line in %s near test %s", testFile, name);
                    abortRun();
                end
                opList.push_back(word);
                nameList.push_back(name);
                addrList.push_back(addr);
                windowList.push_back(window);
                readsList.push_back(reads);
            end
        end
        $fclose(fd);
        if (opList.size() == 0) begin
            $display("The test file %s holds no tests", testFile);
            abortRun();
        end
    endtask

    // Applied shortly after the rising edge
    task automatic driveInputs();
        if (flushPhase == 1) begin
            flush      = 1'b1;
            flushPhase = 2;
        end else if (flushPhase == 3) begin
            flush = 1'b0;
        end
        if (issueIdx < opList.size() && opList[issueIdx] == "fetch") begin
            fetchReq.valid = 1'b1;
            fetchReq.pc    = addrList[issueIdx];
        end else begin
            fetchReq.valid = 1'b0;
            fetchReq.pc    = '0;
        end
    endtask

    // Sampled mid-cycle, describes what the next edge will do
    task automatic sampleOutputs();
        int          testIdx;
        int          acceptCycle;
        logic [31:0] expAddr;
        if (fetchResp.valid) begin
            if (pendingTest.size() == 0) begin
                $display("A fetch response arrived with no fetch outstanding");
                abortRun();
            end
            testIdx     = pendingTest.pop_front();
            acceptCycle = pendingCycle.pop_front();
            checkValue(nameList[testIdx], windowList[testIdx], fetchResp.instr);
            checkValue({nameList[testIdx], " apb reads"}, readsList[testIdx],
                       readCount - lastReadCount);
            if (readsList[testIdx] == 0) begin
                checkValue({nameList[testIdx], " latency"}, 1, cycleCount - acceptCycle);
            end
            lastReadCount = readCount;
        end
        if (apbOut.psel) begin
            checkValue("ready during refill", 0, fetchReady);
        end
        if (apbOut.psel && apbOut.penable && apbIn.pready) begin
            if (pendingTest.size() == 0) begin
                $display("An APB read completed with no fetch outstanding");
                abortRun();
            end
            expAddr = lineBase(addrList[pendingTest[0]]) + 4 * (readCount - lastReadCount);
            checkValue({nameList[pendingTest[0]], " paddr"}, expAddr, apbOut.paddr);
            readCount++;
        end
        if (fetchReq.valid && fetchReady) begin
            pendingTest.push_back(issueIdx);
            pendingCycle.push_back(cycleCount + 1);
            issueIdx++;
        end
        if (flushPhase == 0 && issueIdx < opList.size() && opList[issueIdx] == "flush"
            && pendingTest.size() == 0 && fetchReady) begin
            flushPhase = 1;
        end else if (flushPhase == 2) begin
            checkValue({nameList[issueIdx], " ready before"}, 1, fetchReady);
            flushPhase = 3;
        end else if (flushPhase == 3) begin
            checkValue({nameList[issueIdx], " ready"}, 0, fetchReady);
            issueIdx++;
            flushPhase = 0;
        end
    endtask

    // APB slave with 0 to 3 random wait states
    initial begin
        apbIn    = '0;
        seed     = 32'h6c55_b31c;
        waitLeft = 0;
        inAccess = 1'b0;
        forever begin
            @(posedge clk);
            #driveDelay;
            if (apbOut.psel && apbOut.penable) begin
                if (!inAccess) begin
                    inAccess = 1'b1;
                    waitLeft = $random(seed) & 32'h3;
                end else if (waitLeft > 0) begin
                    waitLeft = waitLeft - 1;
                end
            end else begin
                inAccess = 1'b0;
                waitLeft = 0;
            end
            apbIn.pready = apbOut.psel && apbOut.penable && (waitLeft == 0);
            apbIn.prdata = memWord(apbOut.paddr);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d tests issued",
                     cycleCount, issueIdx, opList.size());
            abortRun();
        end
    end

    initial begin
        fetchReq      = '0;
        flush         = 1'b0;
        readCount     = 0;
        lastReadCount = 0;
        issueIdx      = 0;
        flushPhase    = 0;
        loadTests();
        cycleLimit = resetCycles + opList.size() * (wordsPerLine * 6 + 20);
        @(negedge reset);
        @(negedge clk);
        checkValue("ready after reset", 1, fetchReady);
        checkValue("response after reset", 0, fetchResp.valid);
        checkValue("psel after reset", 0, apbOut.psel);
        checkValue("penable after reset", 0, apbOut.penable);
        while (!allDone()) begin
            @(posedge clk);
            #driveDelay;
            driveInputs();
            @(negedge clk);
            sampleOutputs();
        end
        $display("test passed");
        $finish;
    end

endmodule

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module icacheTop -f icacheTop.f

sim:
	verilator --binary --assert -Wno-fatal --top-module icacheTop_tb \
		-f icacheTop.f -Mdir obj_dir -o icacheTop_sim
	./obj_dir/icacheTop_sim > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "Simulation stopped before the end of the tests"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* icacheTop.f */
+incdir+verilog
verilog/icacheTypesPkg.sv
verilog/busPkg.sv
verilog/icacheMem.sv
verilog/icacheLineFetch.sv
verilog/icacheController.sv
verilog/icacheTop.sv
tests/clockGen.sv
tests/icacheTop_assertions.sv
tests/icacheTop_tb.sv

/* tests/icacheTop_tests.txt */
# operation  name  pc  expected window  APB reads since previous check
# Flush rows carry zeros in the pc and window columns
fetch cold_miss 00001000 5a0010c3 8
fetch same_addr 00001000 5a0010c3 0
fetch next_word 00001004 5a0010c7 0
fetch odd_half 00001002 10c75a00 0
fetch odd_half_mid 0000100a 10cf5a00 0
fetch last_half 0000101e 00005a00 0
fetch top_word 0000101c 5a0010df 0
fetch odd_half_hi 00001016 10db5a00 0
fetch other_set 00002046 208b5a00 8
fetch other_last 0000205e 00005a00 0
fetch conflict_b 00003008 5a0030cb 8
fetch conflict_a 00001004 5a0010c7 8
fetch conflict_b2 00003000 5a0030c3 8
fetch set2_kept 00002050 5a002093 0
fetch high_tag a5c301e0 ffc30123 8
fetch high_odd a5c301f2 0137ffc3 0
fetch low_tag_f 000003e4 5a000327 8
fetch high_again a5c301e0 ffc30123 8
flush flush_all 00000000 00000000 0
fetch after_flush 00002050 5a002093 8
fetch after_flush_b 00003000 5a0030c3 8
fetch after_flush_hit 00003004 5a0030c7 0
flush flush_again 00000000 00000000 0
fetch refetch a5c301f2 0137ffc3 8
fetch refetch_last a5c301fe 0000ffc3 0
